//--- logic/rob_pkg.sv
// ----------------------------------------------------------
// Reorder buffer shared sizes
// ----------------------------------------------------------
package rob_pkg;

  // ----------------------------------------------------------
  // Machine width and buffer geometry
  // ----------------------------------------------------------

  // Instructions per bundle, lane 0 is the older one
  localparam int lanes = 2;

  // Entries in the circular buffer
  localparam int rob_size = 8;

  // Entry index width
  localparam int rob_idx_bits = 3;

  // Holds a count of 0 to rob_size
  // Also the pointer width, index plus one wrap bit
  localparam int count_bits = 4;

  // ----------------------------------------------------------
  // Payload widths
  // ----------------------------------------------------------

  // Architectural destination register number
  localparam int reg_bits = 5;

  // Result value
  localparam int data_bits = 32;

  // Branch target address
  localparam int addr_bits = 32;

  // Exception field and its clean value
  localparam int exc_bits = 2;
  localparam logic [exc_bits-1:0] no_error = 2'b00;

endpackage

//--- logic/dispatch_stage.sv
// ----------------------------------------------------------
// Dispatch stage
// ----------------------------------------------------------
`timescale 1ns/1ns

module dispatch_stage import rob_pkg::*; (
  input  logic                             clock,
  input  logic                             reset,
  input  logic [lanes-1:0]                 in_valid,
  input  logic [lanes-1:0][reg_bits-1:0]   in_dest,
  input  logic [lanes-1:0]                 in_is_branch,
  input  logic [lanes-1:0]                 in_pred_taken,
  output logic                             dispatch_stall,
  input  logic [count_bits-1:0]            free_slots,
  input  logic [lanes-1:0][rob_idx_bits-1:0] alloc_idxs,
  input  logic                             mispredict,
  output logic [lanes-1:0]                 alloc_valid,
  output logic [lanes-1:0][reg_bits-1:0]   alloc_dest,
  output logic [lanes-1:0]                 alloc_is_branch,
  output logic [lanes-1:0]                 alloc_pred_taken,
  output logic [lanes-1:0]                 issue_valid,
  output logic [lanes-1:0][rob_idx_bits-1:0] issue_idx
);

  // One-deep held bundle
  logic [lanes-1:0]               held_valid;
  logic [lanes-1:0][reg_bits-1:0] held_dest;
  logic [lanes-1:0]               held_is_branch;
  logic [lanes-1:0]               held_pred_taken;
  logic [count_bits-1:0]          held_cnt;
  logic                           fits;

  // Number of live lanes in the held bundle
  always_comb begin
    held_cnt = '0;
    for (int i = 0; i < lanes; i++) begin
      held_cnt = held_cnt + count_bits'(held_valid[i]);
    end
  end

  assign fits = (held_cnt <= free_slots);

  // Whole bundle goes or none of it and never during a redirect
  assign alloc_valid      = (fits && !mispredict) ? held_valid : '0;
  assign alloc_dest       = held_dest;
  assign alloc_is_branch  = held_is_branch;
  assign alloc_pred_taken = held_pred_taken;

  // Completion source learns the indices from here
  assign issue_valid = alloc_valid;
  assign issue_idx   = alloc_idxs;

  // Hold the source while the bundle waits for room or while redirecting
  assign dispatch_stall = mispredict || ((|held_valid) && !fits);

  always_ff @(posedge clock) begin
    if (reset) begin
      held_valid <= '0;
    end else if (mispredict) begin
      // Held bundle is younger than the branch
      held_valid <= '0;
    end else if (!dispatch_stall) begin
      held_valid <= in_valid;
    end
  end

  // Bundle payload
  always_ff @(posedge clock) begin
    if (!dispatch_stall) begin
      held_dest       <= in_dest;
      held_is_branch  <= in_is_branch;
      held_pred_taken <= in_pred_taken;
    end
  end

endmodule

//--- logic/rob.sv
// ----------------------------------------------------------
// Reorder buffer
// ----------------------------------------------------------
`timescale 1ns/1ns

module rob import rob_pkg::*; (
  input  logic                               clock,
  input  logic                               reset,
  input  logic [lanes-1:0]                   alloc_valid,
  input  logic [lanes-1:0][reg_bits-1:0]     alloc_dest,
  input  logic [lanes-1:0]                   alloc_is_branch,
  input  logic [lanes-1:0]                   alloc_pred_taken,
  output logic [lanes-1:0][rob_idx_bits-1:0] alloc_idxs,
  output logic [count_bits-1:0]              free_slots,
  input  logic [lanes-1:0]                   cpl_valid,
  input  logic [lanes-1:0][rob_idx_bits-1:0] cpl_idx,
  input  logic [lanes-1:0][data_bits-1:0]    cpl_value,
  input  logic [lanes-1:0]                   cpl_taken,
  input  logic [lanes-1:0][addr_bits-1:0]    cpl_target,
  output logic [lanes-1:0]                   head_valids,
  output logic [lanes-1:0][rob_idx_bits-1:0] head_idx,
  output logic [lanes-1:0][reg_bits-1:0]     head_dest,
  output logic [lanes-1:0][data_bits-1:0]    head_value,
  output logic [lanes-1:0]                   head_is_branch,
  output logic [lanes-1:0]                   head_mispred,
  output logic [lanes-1:0][addr_bits-1:0]    head_target,
  input  logic                               mispredict,
  input  logic [rob_idx_bits-1:0]            mispred_idx
);

  // ----------------------------------------------------------
  // Entry storage as one array per field
  // ----------------------------------------------------------
  logic [rob_size-1:0]  valid;
  logic [rob_size-1:0]  complete;
  logic [rob_size-1:0]  is_branch;
  logic [rob_size-1:0]  pred_taken;
  logic [rob_size-1:0]  taken;
  logic [reg_bits-1:0]  dest      [rob_size];
  logic [data_bits-1:0] value     [rob_size];
  logic [addr_bits-1:0] target    [rob_size];

  // Pointers carry a wrap bit so full and empty differ
  logic [count_bits-1:0]   head_ptr;
  logic [count_bits-1:0]   tail_ptr;
  logic [count_bits-1:0]   inflight;
  logic [count_bits-1:0]   alloc_cnt;
  logic [count_bits-1:0]   release_cnt;
  logic [rob_idx_bits-1:0] flush_idx;

  assign inflight   = tail_ptr - head_ptr;
  assign free_slots = count_bits'(rob_size) - inflight;

  // First entry younger than the mispredicted branch
  assign flush_idx = mispred_idx + 1'b1;

  // Tail slots compacted over the valid lanes
  always_comb begin
    logic [rob_idx_bits-1:0] slot;
    slot = tail_ptr[rob_idx_bits-1:0];
    alloc_cnt = '0;
    for (int i = 0; i < lanes; i++) begin
      alloc_idxs[i] = slot;
      slot = slot + rob_idx_bits'(alloc_valid[i]);
      alloc_cnt = alloc_cnt + count_bits'(alloc_valid[i]);
    end
  end

  // ----------------------------------------------------------
  // Head window and release prefix
  // ----------------------------------------------------------
  always_comb begin
    logic [rob_idx_bits-1:0] idx;
    logic                    prefix;
    prefix = 1'b1;
    release_cnt = '0;
    for (int i = 0; i < lanes; i++) begin
      idx = head_ptr[rob_idx_bits-1:0] + rob_idx_bits'(i);
      // Stops at the first entry outside the window or not yet done
      prefix = prefix && (count_bits'(i) < inflight) && valid[idx] && complete[idx];
      head_valids[i]    = prefix;
      head_idx[i]       = idx;
      head_dest[i]      = dest[idx];
      head_value[i]     = value[idx];
      head_is_branch[i] = is_branch[idx];
      head_mispred[i]   = (taken[idx] != pred_taken[idx]);
      head_target[i]    = target[idx];
      release_cnt = release_cnt + count_bits'(prefix);
    end
  end

  // ----------------------------------------------------------
  // Pointers and status bits
  // ----------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      valid    <= '0;
      complete <= '0;
    end else begin
      for (int i = 0; i < lanes; i++) begin
        if (head_valids[i]) begin
          valid[head_idx[i]]    <= 1'b0;
          complete[head_idx[i]] <= 1'b0;
        end
      end
      if (mispredict) begin
        // Truncate after the branch so the buffer ends up empty
        head_ptr <= count_bits'(flush_idx);
        tail_ptr <= count_bits'(flush_idx);
        valid    <= '0;
        complete <= '0;
      end else begin
        head_ptr <= head_ptr + release_cnt;
        tail_ptr <= tail_ptr + alloc_cnt;
        for (int i = 0; i < lanes; i++) begin
          if (alloc_valid[i]) begin
            valid[alloc_idxs[i]]    <= 1'b1;
            complete[alloc_idxs[i]] <= 1'b0;
          end
        end
      end
      // Completion always lands
      for (int i = 0; i < lanes; i++) begin
        if (cpl_valid[i]) begin
          complete[cpl_idx[i]] <= 1'b1;
        end
      end
    end
  end

  // Payload fields
  always_ff @(posedge clock) begin
    for (int i = 0; i < lanes; i++) begin
      if (alloc_valid[i] && !mispredict) begin
        dest[alloc_idxs[i]]       <= alloc_dest[i];
        is_branch[alloc_idxs[i]]  <= alloc_is_branch[i];
        pred_taken[alloc_idxs[i]] <= alloc_pred_taken[i];
        // Non-branches never show a mispredict
        taken[alloc_idxs[i]]      <= alloc_pred_taken[i];
      end
      if (cpl_valid[i]) begin
        value[cpl_idx[i]] <= cpl_value[i];
        if (is_branch[cpl_idx[i]]) begin
          taken[cpl_idx[i]]  <= cpl_taken[i];
          target[cpl_idx[i]] <= cpl_target[i];
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  a_alloc_room: assert property (@(posedge clock) disable iff (reset)
    alloc_cnt <= free_slots)
    else $error("allocation of %0d exceeds free_slots %0d", alloc_cnt, free_slots);

  for (genvar g = 0; g < lanes; g++) begin : g_lane_checks
    a_cpl_live: assert property (@(posedge clock) disable iff (reset)
      cpl_valid[g] |-> valid[cpl_idx[g]])
      else $error("completion to idle entry %0d", cpl_idx[g]);
  end

endmodule

//--- logic/retire_stage.sv
// ----------------------------------------------------------
// Retire stage
// ----------------------------------------------------------
`timescale 1ns/1ns

module retire_stage import rob_pkg::*; (
  input  logic [lanes-1:0]                   head_valids,
  input  logic [lanes-1:0][rob_idx_bits-1:0] head_idx,
  input  logic [lanes-1:0][reg_bits-1:0]     head_dest,
  input  logic [lanes-1:0][data_bits-1:0]    head_value,
  input  logic [lanes-1:0]                   head_is_branch,
  input  logic [lanes-1:0]                   head_mispred,
  input  logic [lanes-1:0][addr_bits-1:0]    head_target,
  output logic [lanes-1:0]                   commit_valid,
  output logic [lanes-1:0][reg_bits-1:0]     commit_dest,
  output logic [lanes-1:0][data_bits-1:0]    commit_value,
  output logic                               mispredict,
  output logic [rob_idx_bits-1:0]            mispred_idx,
  output logic                               redirect_valid,
  output logic [addr_bits-1:0]               redirect_target
);

  // ----------------------------------------------------------
  // Oldest-first walk over the released lanes
  // ----------------------------------------------------------

  // Set once a mispredicted branch has been passed
  logic blocked;

  always_comb begin
    blocked         = 1'b0;
    commit_valid    = '0;
    mispredict      = 1'b0;
    mispred_idx     = '0;
    redirect_target = '0;
    for (int i = 0; i < lanes; i++) begin
      if (head_valids[i] && !blocked) begin
        // Branch itself commits
        commit_valid[i] = 1'b1;
        if (head_is_branch[i] && head_mispred[i]) begin
          blocked         = 1'b1;
          mispredict      = 1'b1;
          mispred_idx     = head_idx[i];
          redirect_target = head_target[i];
        end
      end
    end
  end

  // Payload passes straight through, commit_valid qualifies it
  assign commit_dest  = head_dest;
  assign commit_value = head_value;

  // Fetch redirect coincides with the flush
  assign redirect_valid = mispredict;

endmodule

//--- logic/rob_subsystem.sv
// ----------------------------------------------------------
// Commit subsystem top
// ----------------------------------------------------------
`timescale 1ns/1ns

module rob_subsystem import rob_pkg::*; (
  input  logic                               clock,
  input  logic                               reset,
  // Instruction source
  input  logic [lanes-1:0]                   in_valid,
  input  logic [lanes-1:0][reg_bits-1:0]     in_dest,
  input  logic [lanes-1:0]                   in_is_branch,
  input  logic [lanes-1:0]                   in_pred_taken,
  output logic                               dispatch_stall,
  output logic [lanes-1:0]                   issue_valid,
  output logic [lanes-1:0][rob_idx_bits-1:0] issue_idx,
  // Completion
  input  logic [lanes-1:0]                   cpl_valid,
  input  logic [lanes-1:0][rob_idx_bits-1:0] cpl_idx,
  input  logic [lanes-1:0][data_bits-1:0]    cpl_value,
  input  logic [lanes-1:0]                   cpl_taken,
  input  logic [lanes-1:0][addr_bits-1:0]    cpl_target,
  // Commit and redirect
  output logic [lanes-1:0]                   commit_valid,
  output logic [lanes-1:0][reg_bits-1:0]     commit_dest,
  output logic [lanes-1:0][data_bits-1:0]    commit_value,
  output logic                               redirect_valid,
  output logic [addr_bits-1:0]               redirect_target
);

  // Dispatch to buffer
  logic [lanes-1:0]                   alloc_valid;
  logic [lanes-1:0][reg_bits-1:0]     alloc_dest;
  logic [lanes-1:0]                   alloc_is_branch;
  logic [lanes-1:0]                   alloc_pred_taken;
  logic [lanes-1:0][rob_idx_bits-1:0] alloc_idxs;
  logic [count_bits-1:0]              free_slots;

  // Buffer head to retire
  logic [lanes-1:0]                   head_valids;
  logic [lanes-1:0][rob_idx_bits-1:0] head_idx;
  logic [lanes-1:0][reg_bits-1:0]     head_dest;
  logic [lanes-1:0][data_bits-1:0]    head_value;
  logic [lanes-1:0]                   head_is_branch;
  logic [lanes-1:0]                   head_mispred;
  logic [lanes-1:0][addr_bits-1:0]    head_target;

  // Flush back from retire
  logic                               mispredict;
  logic [rob_idx_bits-1:0]            mispred_idx;

  dispatch_stage u_dispatch (
    .clock, .reset,
    .in_valid, .in_dest, .in_is_branch, .in_pred_taken,
    .dispatch_stall,
    .free_slots, .alloc_idxs, .mispredict,
    .alloc_valid, .alloc_dest, .alloc_is_branch, .alloc_pred_taken,
    .issue_valid, .issue_idx
  );

  rob u_rob (
    .clock, .reset,
    .alloc_valid, .alloc_dest, .alloc_is_branch, .alloc_pred_taken,
    .alloc_idxs, .free_slots,
    .cpl_valid, .cpl_idx, .cpl_value, .cpl_taken, .cpl_target,
    .head_valids, .head_idx, .head_dest, .head_value,
    .head_is_branch, .head_mispred, .head_target,
    .mispredict, .mispred_idx
  );

  retire_stage u_retire (
    .head_valids, .head_idx, .head_dest, .head_value,
    .head_is_branch, .head_mispred, .head_target,
    .commit_valid, .commit_dest, .commit_value,
    .mispredict, .mispred_idx,
    .redirect_valid, .redirect_target
  );

endmodule

//--- test/rob_tb.sv
// ----------------------------------------------------------
// Reorder buffer subsystem testbench
// ----------------------------------------------------------
`timescale 1ns/1ns

module rob_tb import rob_pkg::*; ();

  localparam int stall_limit = 64;
  localparam int max_cycles  = 2000;

  logic                               clock;
  logic                               reset;
  logic [lanes-1:0]                   in_valid;
  logic [lanes-1:0][reg_bits-1:0]     in_dest;
  logic [lanes-1:0]                   in_is_branch;
  logic [lanes-1:0]                   in_pred_taken;
  logic                               dispatch_stall;
  logic [lanes-1:0]                   issue_valid;
  logic [lanes-1:0][rob_idx_bits-1:0] issue_idx;
  logic [lanes-1:0]                   cpl_valid;
  logic [lanes-1:0][rob_idx_bits-1:0] cpl_idx;
  logic [lanes-1:0][data_bits-1:0]    cpl_value;
  logic [lanes-1:0]                   cpl_taken;
  logic [lanes-1:0][addr_bits-1:0]    cpl_target;
  logic [lanes-1:0]                   commit_valid;
  logic [lanes-1:0][reg_bits-1:0]     commit_dest;
  logic [lanes-1:0][data_bits-1:0]    commit_value;
  logic                               redirect_valid;
  logic [addr_bits-1:0]               redirect_target;

  // Program table with one entry per row in each queue
  logic [reg_bits-1:0]  t_dest   [$];
  logic [data_bits-1:0] t_value  [$];
  bit                   t_br     [$];
  bit                   t_pred   [$];
  bit                   t_taken  [$];
  logic [addr_bits-1:0] t_target [$];
  bit                   t_wrong  [$];

  // Source, completion and commit bookkeeping
  int          exp_rows [$];
  int          pend_idx [$];
  int          pend_row [$];
  int          row_slot [int];
  int          held_row [lanes];
  int          drv_row  [lanes];
  int          held_n;
  int          drv_n;
  int          exp_tail;
  int          feed_ptr;
  int          commit_ptr;
  int          errors;
  int          redirects;
  int          stall_run;
  int          cycles;
  bit          go_low;
  bit          stall_seen;
  bit          cpl_on;
  bit          timed_out;
  logic [31:0] rnd_state;

  rob_subsystem u_dut (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic add_row(input logic [reg_bits-1:0] d, input logic [data_bits-1:0] v,
                         input bit br, input bit pred, input bit tk,
                         input logic [addr_bits-1:0] tgt, input bit wrong);
    t_dest.push_back(d);
    t_value.push_back(v);
    t_br.push_back(br);
    t_pred.push_back(pred);
    t_taken.push_back(tk);
    t_target.push_back(tgt);
    t_wrong.push_back(wrong);
  endtask

  // ----------------------------------------------------------
  // Commit and redirect checker sampled at the falling edge
  // ----------------------------------------------------------
  task automatic check_commits();
    bit                   want_redirect;
    logic [addr_bits-1:0] want_target;
    int                   r;
    want_redirect = 1'b0;
    want_target   = '0;
    // Lane 0 always carries the older commit
    if (commit_valid[1] && !commit_valid[0]) begin
      errors++;
      $display("Fail %0t ns: commit_valid expected 01 or 11 actual %b", $time, commit_valid);
    end
    for (int l = 0; l < lanes; l++) begin
      if (commit_valid[l]) begin
        if (commit_ptr >= exp_rows.size()) begin
          errors++;
          $display("%0t ns: lane %0d committed after the whole program", $time, l);
        end else begin
          r = exp_rows[commit_ptr];
          if (commit_dest[l] !== t_dest[r]) begin
            errors++;
            $display("Fail %0t ns: commit_dest[%0d] expected %0h actual %0h",
                     $time, l, t_dest[r], commit_dest[l]);
          end
          if (commit_value[l] !== t_value[r]) begin
            errors++;
            $display("Fail %0t ns: commit_value[%0d] expected %0h actual %0h",
                     $time, l, t_value[r], commit_value[l]);
          end
          if (t_br[r] && (t_taken[r] != t_pred[r])) begin
            want_redirect = 1'b1;
            want_target   = t_target[r];
          end
          commit_ptr++;
        end
      end
    end
    if (redirect_valid !== want_redirect) begin
      errors++;
      $display("Fail %0t ns: redirect_valid expected %0b actual %0b",
               $time, want_redirect, redirect_valid);
    end else if (want_redirect && (redirect_target !== want_target)) begin
      errors++;
      $display("Fail %0t ns: redirect_target expected %0h actual %0h",
               $time, want_target, redirect_target);
    end
  endtask

  // ----------------------------------------------------------
  // One cycle of source, completion and checking
  // ----------------------------------------------------------
  task automatic step();
    int r;
    int n;
    int k;
    // Bundle driven last cycle left the source at the rising edge
    if (go_low) begin
      held_n   = drv_n;
      held_row = drv_row;
      feed_ptr = feed_ptr + drv_n;
    end
    check_commits();
    if (redirect_valid === 1'b1) begin
      redirects++;
      // Everything younger than the branch is flushed and fetch restarts past the wrong path
      held_n = 0;
      pend_idx.delete();
      pend_row.delete();
      if (commit_ptr > 0) begin
        r = exp_rows[commit_ptr-1];
        // Allocation restarts just past the branch
        exp_tail = (row_slot[r] + 1) % rob_size;
        r++;
        while (r < t_dest.size() && t_wrong[r]) begin
          r++;
        end
        feed_ptr = r;
      end
    end
    // Up to two completions picked at random from the in-flight list
    cpl_valid  = '0;
    cpl_idx    = '0;
    cpl_value  = '0;
    cpl_taken  = '0;
    cpl_target = '0;
    if (cpl_on && (redirect_valid !== 1'b1)) begin
      rnd_state = xorshift(rnd_state);
      n = int'(rnd_state % 3);
      for (int l = 0; l < n; l++) begin
        if (pend_idx.size() > 0) begin
          rnd_state = xorshift(rnd_state);
          k = int'(rnd_state % pend_idx.size());
          r = pend_row[k];
          cpl_valid[l]  = 1'b1;
          cpl_idx[l]    = rob_idx_bits'(pend_idx[k]);
          cpl_value[l]  = t_value[r];
          cpl_taken[l]  = t_br[r] ? t_taken[r] : 1'b0;
          cpl_target[l] = t_target[r];
          pend_idx.delete(k);
          pend_row.delete(k);
        end
      end
    end
    // Newly allocated entries become eligible from the next cycle
    if ((issue_valid !== '0) && (redirect_valid !== 1'b1)) begin
      if ($countones(issue_valid) != held_n) begin
        errors++;
        $display("Fail %0t ns: issue_valid lanes expected %0d actual %0d",
                 $time, held_n, $countones(issue_valid));
      end
      for (int l = 0; l < lanes; l++) begin
        if (issue_valid[l] && (l < held_n)) begin
          // Slots are handed out in order around the ring
          if (issue_idx[l] !== rob_idx_bits'(exp_tail)) begin
            errors++;
            $display("Fail %0t ns: issue_idx[%0d] expected %0d actual %0d",
                     $time, l, exp_tail, issue_idx[l]);
          end
          row_slot[held_row[l]] = exp_tail;
          exp_tail = (exp_tail + 1) % rob_size;
          pend_idx.push_back(int'(issue_idx[l]));
          pend_row.push_back(held_row[l]);
        end
      end
    end
    // Next bundle of two rows in program order
    drv_n = t_dest.size() - feed_ptr;
    if (drv_n > lanes) drv_n = lanes;
    if (drv_n < 0) drv_n = 0;
    in_valid      = '0;
    in_dest       = '0;
    in_is_branch  = '0;
    in_pred_taken = '0;
    for (int l = 0; l < lanes; l++) begin
      drv_row[l] = feed_ptr + l;
      if (l < drv_n) begin
        in_valid[l]      = 1'b1;
        in_dest[l]       = t_dest[feed_ptr+l];
        in_is_branch[l]  = t_br[feed_ptr+l];
        in_pred_taken[l] = t_pred[feed_ptr+l];
      end
    end
    go_low = (dispatch_stall === 1'b0);
    if (dispatch_stall === 1'b1) begin
      stall_run++;
      // Buffer filled with completions withheld
      if ((feed_ptr > rob_size) && (redirect_valid !== 1'b1)) begin
        stall_seen = 1'b1;
        cpl_on     = 1'b1;
      end
    end else begin
      stall_run = 0;
    end
    if (stall_run > stall_limit) begin
      errors++;
      timed_out = 1'b1;
      $display("%0t ns: dispatch_stall stayed high for %0d cycles", $time, stall_run);
    end
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    reset = 1'b1;
    in_valid = '0;
    in_dest = '0;
    in_is_branch = '0;
    in_pred_taken = '0;
    cpl_valid = '0;
    cpl_idx = '0;
    cpl_value = '0;
    cpl_taken = '0;
    cpl_target = '0;
    rnd_state = 32'd7866;
    feed_ptr   = 0;
    commit_ptr = 0;
    errors     = 0;
    redirects  = 0;
    stall_run  = 0;
    cycles     = 0;
    held_n     = 0;
    drv_n      = 0;
    exp_tail   = 0;
    go_low     = 1'b0;
    stall_seen = 1'b0;
    cpl_on     = 1'b0;
    timed_out  = 1'b0;

    // dest, value, branch, predicted, taken, target, wrong path
    add_row(5'd1,  32'h0000_1001, 0, 0, 0, 32'h0, 0);
    add_row(5'd2,  32'h0000_1002, 0, 0, 0, 32'h0, 0);
    add_row(5'd3,  32'h0000_1003, 0, 0, 0, 32'h0, 0);
    add_row(5'd4,  32'h0000_1004, 0, 0, 0, 32'h0, 0);
    add_row(5'd5,  32'h0000_1005, 0, 0, 0, 32'h0, 0);
    add_row(5'd0,  32'h0000_1006, 1, 1, 1, 32'h0000_0400, 0);
    add_row(5'd6,  32'h0000_1007, 0, 0, 0, 32'h0, 0);
    add_row(5'd7,  32'h0000_1008, 0, 0, 0, 32'h0, 0);
    add_row(5'd8,  32'h0000_1009, 0, 0, 0, 32'h0, 0);
    add_row(5'd0,  32'h0000_100a, 1, 0, 0, 32'h0000_0800, 0);
    add_row(5'd9,  32'h0000_100b, 0, 0, 0, 32'h0, 0);
    add_row(5'd10, 32'h0000_100c, 0, 0, 0, 32'h0, 0);
    add_row(5'd11, 32'h0000_100d, 0, 0, 0, 32'h0, 0);
    add_row(5'd0,  32'h0000_100e, 1, 0, 1, 32'h0000_2040, 0);
    add_row(5'd20, 32'hdead_0001, 0, 0, 0, 32'h0, 1);
    add_row(5'd21, 32'hdead_0002, 0, 0, 0, 32'h0, 1);
    add_row(5'd22, 32'hdead_0003, 0, 0, 0, 32'h0, 1);
    add_row(5'd12, 32'h0000_2040, 0, 0, 0, 32'h0, 0);
    add_row(5'd13, 32'h0000_2041, 0, 0, 0, 32'h0, 0);
    add_row(5'd0,  32'h0000_2042, 1, 1, 0, 32'h0000_3000, 0);
    add_row(5'd23, 32'hdead_0004, 0, 0, 0, 32'h0, 1);
    add_row(5'd24, 32'hdead_0005, 0, 0, 0, 32'h0, 1);
    add_row(5'd14, 32'h0000_3000, 0, 0, 0, 32'h0, 0);
    add_row(5'd15, 32'h0000_3001, 0, 0, 0, 32'h0, 0);

    // Commit order is the table minus the wrong path
    for (int r = 0; r < t_dest.size(); r++) begin
      if (!t_wrong[r]) exp_rows.push_back(r);
    end

    repeat (10) @(negedge clock);
    reset = 1'b0;

    // Idle outputs straight out of reset
    if (commit_valid !== '0) begin
      errors++;
      $display("Fail %0t ns: commit_valid expected 0 actual %b", $time, commit_valid);
    end
    if (redirect_valid !== 1'b0) begin
      errors++;
      $display("Fail %0t ns: redirect_valid expected 0 actual %b", $time, redirect_valid);
    end
    if (issue_valid !== '0) begin
      errors++;
      $display("Fail %0t ns: issue_valid expected 0 actual %b", $time, issue_valid);
    end
    if (dispatch_stall !== 1'b0) begin
      errors++;
      $display("Fail %0t ns: dispatch_stall expected 0 actual %b", $time, dispatch_stall);
    end

    while ((commit_ptr < exp_rows.size()) && !timed_out && (cycles < max_cycles)) begin
      @(negedge clock);
      step();
      cycles++;
    end
    if ((commit_ptr < exp_rows.size()) && !timed_out) begin
      errors++;
      $display("Timeout with %0d of %0d instructions committed", commit_ptr, exp_rows.size());
    end

    // Any late commit in the quiet window is a duplicate or a wrong-path row
    repeat (8) begin
      @(negedge clock);
      step();
    end

    if (!stall_seen) begin
      errors++;
      $display("dispatch_stall never rose while the buffer was full");
    end
    if (redirects != 2) begin
      errors++;
      $display("Expected two redirects but saw %0d", redirects);
    end

    $display("Errors: %0d, commits %0d of %0d, redirects %0d",
             errors, commit_ptr, exp_rows.size(), redirects);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- filelist.f
logic/rob_pkg.sv
logic/dispatch_stage.sv
logic/rob.sv
logic/retire_stage.sv
logic/rob_subsystem.sv
test/rob_tb.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the reorder buffer testbench
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
  --top-module rob_tb -f filelist.f -o Vrob_tb
status=0
./obj_dir/Vrob_tb > sim.log 2>&1 || status=$?
cat sim.log
if grep -q -F '*** TEST FAILED ***' sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q -F '*** TEST PASSED ***' sim.log; then
  echo "Simulation did not finish cleanly"
  exit 1
fi
echo "Simulation finished without errors"
